//--- all.f
hw/msx_bus_pkg.sv
hw/mapper_pkg.sv
hw/mem_bus_if.sv
hw/io_port_decoder.sv
hw/segment_mapper.sv
hw/ram_arbiter.sv
hw/mapped_ram.sv
hw/msx2_mapper_top.sv
dv/tb_clock.sv
dv/tb_mapper.sv

//--- Makefile
SRCS := $(wildcard hw/*.sv dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_mapper: all.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mapper -f all.f

run: obj_dir/Vtb_mapper
	./obj_dir/Vtb_mapper | tee sim.log
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_mapper.sv
module tb_mapper import msx_bus_pkg::*, mapper_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 20;   // Cycles per handshake wait

    logic                  clk;
    logic                  reset;
    logic [cpu_addr_w-1:0] cpu_addr;
    logic [cpu_data_w-1:0] cpu_wdata;
    logic                  cpu_iorq;
    logic                  cpu_mreq;
    logic                  cpu_m1;
    logic                  cpu_rd;
    logic                  cpu_wr;
    logic [cpu_data_w-1:0] cpu_rdata;
    logic                  cpu_wait;
    logic                  load_req;
    logic                  load_we;
    logic [phys_aw-1:0]    load_addr;
    logic [cpu_data_w-1:0] load_wdata;
    logic [cpu_data_w-1:0] load_rdata;
    logic                  load_ack;

    logic [seg_w-1:0] seg_model [n_pages];   // Shadow segment registers
    logic [7:0]       ram_model [int];       // Written physical bytes only
    logic [31:0]      rng_state = 32'h705e;
    int               value_errors = 0;
    int               protocol_errors = 0;
    int               timeouts = 0;

    tb_clock clock_i (
        .clk   (clk),
        .reset (reset)
    );

    msx2_mapper_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_iorq   (cpu_iorq),
        .cpu_mreq   (cpu_mreq),
        .cpu_m1     (cpu_m1),
        .cpu_rd     (cpu_rd),
        .cpu_wr     (cpu_wr),
        .cpu_rdata  (cpu_rdata),
        .cpu_wait   (cpu_wait),
        .load_req   (load_req),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_wdata (load_wdata),
        .load_rdata (load_rdata),
        .load_ack   (load_ack)
    );

    // Bus protocol rules
    assert property (@(posedge clk) disable iff (reset) (cpu_iorq && !cpu_mreq) |-> !cpu_wait)
        else begin
            protocol_errors++;
            $display("cpu_wait was high during an I/O cycle");
        end
    assert property (@(posedge clk) disable iff (reset) load_ack |-> !$past(load_ack))
        else begin
            protocol_errors++;
            $display("load_ack stayed high for more than one cycle");
        end
    assert property (@(posedge clk) disable iff (reset) load_ack |-> load_req)
        else begin
            protocol_errors++;
            $display("load_ack came without a loader request");
        end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // Stored bits plus ones above the mapper size
    function automatic logic [7:0] readback(input logic [seg_w-1:0] seg);
        return 8'(seg) | ~seg_mask;
    endfunction

    function automatic logic [phys_aw-1:0] translate(input logic [cpu_addr_w-1:0] a);
        return {seg_model[a[cpu_addr_w-1:page_lsb]], a[page_off_w-1:0]};
    endfunction

    task automatic check_byte(input string test, input logic [7:0] expected,
                              input logic [7:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("FAIL %s: expected %02h, actual %02h", test, expected, actual);
        end
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data, input logic m1);
        @(posedge clk);
        cpu_addr  <= {8'h00, port};
        cpu_wdata <= data;
        cpu_m1    <= m1;
        cpu_iorq  <= 1'b1;
        cpu_wr    <= 1'b1;
        @(posedge clk);   // Register loads here
        cpu_iorq  <= 1'b0;
        cpu_wr    <= 1'b0;
        cpu_m1    <= 1'b0;
    endtask

    task automatic io_read(input logic [7:0] port, output logic [7:0] data);
        @(posedge clk);
        cpu_addr <= {8'h00, port};
        cpu_iorq <= 1'b1;
        cpu_rd   <= 1'b1;
        @(negedge clk);
        data = cpu_rdata;   // Combinational read
        @(posedge clk);
        cpu_iorq <= 1'b0;
        cpu_rd   <= 1'b0;
    endtask

    task automatic map_page(input int page, input logic [7:0] value);
        io_write(port_seg_base + 8'(page), value, 1'b0);
        seg_model[page] = seg_w'(value & seg_mask);
    endtask

    task automatic cpu_mem(input logic [cpu_addr_w-1:0] addr, input logic we,
                           input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        @(posedge clk);
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        cpu_mreq  <= 1'b1;
        cpu_rd    <= !we;
        cpu_wr    <= we;
        waited = 0;
        @(negedge clk);
        while (cpu_wait && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (cpu_wait) begin
            timeouts++;
            $display("Timeout: cpu_wait never dropped for CPU address %04h", addr);
        end
        rdata = cpu_rdata;
        @(posedge clk);
        cpu_mreq <= 1'b0;
        cpu_rd   <= 1'b0;
        cpu_wr   <= 1'b0;
    endtask

    task automatic load_mem(input logic [phys_aw-1:0] addr, input logic we,
                            input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        @(posedge clk);
        load_req   <= 1'b1;
        load_we    <= we;
        load_addr  <= addr;
        load_wdata <= wdata;
        waited = 0;
        @(negedge clk);
        while (!load_ack && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!load_ack) begin
            timeouts++;
            $display("Timeout: no load_ack for physical address %05h", addr);
        end
        rdata = load_rdata;   // Valid in the ack cycle
        @(posedge clk);
        load_req <= 1'b0;
        load_we  <= 1'b0;
    endtask

    task automatic cpu_write(input logic [cpu_addr_w-1:0] addr, input logic [7:0] data);
        logic [7:0] unused_rd;
        ram_model[int'(translate(addr))] = data;
        cpu_mem(addr, 1'b1, data, unused_rd);
    endtask

    task automatic load_write(input logic [phys_aw-1:0] addr, input logic [7:0] data);
        logic [7:0] unused_rd;
        ram_model[int'(addr)] = data;
        load_mem(addr, 1'b1, data, unused_rd);
    endtask

    task automatic cpu_check(input string test, input logic [cpu_addr_w-1:0] addr);
        logic [7:0]         data;
        logic [phys_aw-1:0] pa;
        pa = translate(addr);
        cpu_mem(addr, 1'b0, 8'h00, data);
        check_byte(test, ram_model[int'(pa)], data);
    endtask

    task automatic load_check(input string test, input logic [phys_aw-1:0] addr);
        logic [7:0] data;
        load_mem(addr, 1'b0, 8'h00, data);
        check_byte(test, ram_model[int'(addr)], data);
    endtask

    initial begin
        logic [7:0]            data;
        logic [7:0]            val;
        logic [31:0]           r;
        logic [cpu_addr_w-1:0] cpu_a;
        logic [phys_aw-1:0]    load_a;
        logic [page_off_w-1:0] offs [mapper_segments];
        logic [phys_aw-1:0]    phys [8];
        time                   t_cpu;
        time                   t_load;
        int                    waited;

        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_iorq   = 1'b0;
        cpu_mreq   = 1'b0;
        cpu_m1     = 1'b0;
        cpu_rd     = 1'b0;
        cpu_wr     = 1'b0;
        load_req   = 1'b0;
        load_we    = 1'b0;
        load_addr  = '0;
        load_wdata = '0;
        for (int p = 0; p < n_pages; p++) begin
            seg_model[p] = '0;
        end

        waited = 0;
        while (reset && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (reset) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end

        // Reset state and read-back of cleared registers
        @(negedge clk);
        check_byte("reset_wait", 8'h00, {7'b0, cpu_wait});
        check_byte("reset_ack", 8'h00, {7'b0, load_ack});
        for (int p = 0; p < n_pages; p++) begin
            io_read(port_seg_base + 8'(p), data);
            check_byte("reset_readback", readback('0), data);
        end

        for (int p = 0; p < n_pages; p++) begin
            r = xorshift32();
            val = r[7:0];
            map_page(p, val);
            io_read(port_seg_base + 8'(p), data);
            check_byte("seg_readback", (val & seg_mask) | ~seg_mask, data);
        end
        // Interrupt acknowledge and foreign ports leave the registers alone
        // Low bits differ from the register a stray write would hit
        r = xorshift32();
        io_write(port_seg_base, {r[7:seg_w], ~seg_model[0]}, 1'b1);
        io_write(8'hFB, {r[15:8+seg_w], ~seg_model[3]}, 1'b0);
        io_write(8'h00, {r[23:16+seg_w], ~seg_model[0]}, 1'b0);
        for (int p = 0; p < n_pages; p++) begin
            io_read(port_seg_base + 8'(p), data);
            check_byte("seg_untouched", readback(seg_model[p]), data);
        end
        io_read(8'hFB, data);
        check_byte("foreign_port_fb", 8'hFF, data);
        io_read(r[31:24] & 8'h7F, data);
        check_byte("foreign_port_rand", 8'hFF, data);

        // First tie since reset
        r = xorshift32();
        cpu_a = r[15:0];
        load_a = r[31:32-phys_aw];
        if (translate(cpu_a) == load_a) begin
            load_a[0] = ~load_a[0];
        end
        fork
            begin
                cpu_write(cpu_a, r[7:0]);
                t_cpu = $time;
            end
            begin
                load_write(load_a, r[15:8]);
                t_load = $time;
            end
        join
        assert (t_cpu < t_load) else begin
            protocol_errors++;
            $display("Loader was served before the CPU on the first tie after reset");
        end

        // Loader fills every segment, CPU reads through the pages
        for (int s = 0; s < mapper_segments; s++) begin
            r = xorshift32();
            offs[s] = r[page_off_w-1:0];
            load_write({seg_w'(s), offs[s]}, r[31:24]);
        end
        for (int s = 0; s < mapper_segments; s++) begin
            map_page(s % n_pages, 8'(s));
            cpu_check("load_to_cpu", {page_w'(s % n_pages), offs[s]});
        end

        r = xorshift32();
        map_page(0, r[7:0]);
        map_page(1, r[15:8]);
        map_page(2, r[23:16]);
        map_page(3, r[23:16]);   // Pages 2 and 3 alias
        for (int i = 0; i < 8; i++) begin
            r = xorshift32();
            cpu_a = {page_w'(i % n_pages), r[page_off_w-1:0]};
            phys[i] = translate(cpu_a);
            cpu_write(cpu_a, r[31:24]);
        end
        for (int i = 0; i < 8; i++) begin
            load_check("cpu_to_load", phys[i]);
        end
        r = xorshift32();
        cpu_write({2'd2, r[page_off_w-1:0]}, r[31:24]);
        cpu_mem({2'd3, r[page_off_w-1:0]}, 1'b0, 8'h00, data);
        check_byte("page_alias", r[31:24], data);

        // Both masters at once
        for (int i = 0; i < 16; i++) begin
            r = xorshift32();
            cpu_a = r[15:0];
            r = xorshift32();
            load_a = r[phys_aw-1:0];
            if (translate(cpu_a) == load_a) begin
                load_a[0] = ~load_a[0];
            end
            r = xorshift32();
            fork
                cpu_write(cpu_a, r[7:0]);
                load_write(load_a, r[15:8]);
            join
            fork
                cpu_check("contend_cpu", cpu_a);
                load_check("contend_load", load_a);
            join
        end

        repeat (2) @(posedge clk);
        $display("Value errors: %0d, protocol errors: %0d, timeouts: %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- dv/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- hw/msx2_mapper_top.sv
module msx2_mapper_top import msx_bus_pkg::*, mapper_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    // Z80 side
    input  logic [cpu_addr_w-1:0] cpu_addr,
    input  logic [cpu_data_w-1:0] cpu_wdata,
    input  logic                  cpu_iorq,
    input  logic                  cpu_mreq,
    input  logic                  cpu_m1,
    input  logic                  cpu_rd,
    input  logic                  cpu_wr,
    output logic [cpu_data_w-1:0] cpu_rdata,
    output logic                  cpu_wait,

    // Loader side, physical addresses
    input  logic                  load_req,
    input  logic                  load_we,
    input  logic [phys_aw-1:0]    load_addr,
    input  logic [cpu_data_w-1:0] load_wdata,
    output logic [cpu_data_w-1:0] load_rdata,
    output logic                  load_ack
);

    logic [page_w-1:0]     seg_sel;
    logic                  seg_wr;
    logic                  seg_rd;
    logic                  io_miss_rd;
    logic [cpu_data_w-1:0] io_rdata;
    logic [cpu_data_w-1:0] cpu_rdata_mem;

    mem_bus_if cpu_bus ();    // Mapper to arbiter
    mem_bus_if load_bus ();   // Loader to arbiter
    mem_bus_if ram_bus ();    // Arbiter to RAM

    io_port_decoder io_dec_i (
        .cpu_addr   (cpu_addr),
        .cpu_iorq   (cpu_iorq),
        .cpu_m1     (cpu_m1),
        .cpu_rd     (cpu_rd),
        .cpu_wr     (cpu_wr),
        .seg_sel    (seg_sel),
        .seg_wr     (seg_wr),
        .seg_rd     (seg_rd),
        .io_miss_rd (io_miss_rd)
    );

    segment_mapper mapper_i (
        .clk           (clk),
        .reset         (reset),
        .seg_sel       (seg_sel),
        .seg_wr        (seg_wr),
        .seg_rd        (seg_rd),
        .cpu_addr      (cpu_addr),
        .cpu_wdata     (cpu_wdata),
        .cpu_mreq      (cpu_mreq),
        .cpu_rd        (cpu_rd),
        .cpu_wr        (cpu_wr),
        .io_rdata      (io_rdata),
        .cpu_rdata_mem (cpu_rdata_mem),
        .cpu_wait      (cpu_wait),
        .mem           (cpu_bus)
    );

    // Loader plain ports onto its bus
    assign load_bus.req   = load_req;
    assign load_bus.we    = load_we;
    assign load_bus.addr  = load_addr;
    assign load_bus.wdata = load_wdata;
    assign load_rdata     = load_bus.rdata;
    assign load_ack       = load_bus.ack;

    ram_arbiter arb_i (
        .clk    (clk),
        .reset  (reset),
        .cpu_m  (cpu_bus),
        .load_m (load_bus),
        .ram    (ram_bus)
    );

    mapped_ram ram_i (
        .clk   (clk),
        .reset (reset),
        .port  (ram_bus)
    );

    // Read data by cycle type
    always_comb begin
        if (io_miss_rd) begin
            cpu_rdata = 8'hFF;           // Port not ours
        end else if (seg_rd) begin
            cpu_rdata = io_rdata;
        end else begin
            cpu_rdata = cpu_rdata_mem;   // Last memory read
        end
    end

endmodule

//--- hw/mapped_ram.sv
module mapped_ram import msx_bus_pkg::*, mapper_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    mem_bus_if.slave port
);

    logic [cpu_data_w-1:0] mem [2**phys_aw];
    logic                  accept;

    // A request still held in the ack cycle is not taken twice
    assign accept = port.req && !port.ack;

    always_ff @(posedge clk) begin
        if (accept) begin
            if (port.we) begin
                mem[port.addr] <= port.wdata;
            end else begin
                port.rdata <= mem[port.addr];   // Registered read
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            port.ack <= 1'b0;
        end else begin
            port.ack <= accept;   // Exactly one cycle after sampling req
        end
    end

endmodule

//--- hw/ram_arbiter.sv
module ram_arbiter import mapper_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    mem_bus_if.slave  cpu_m,
    mem_bus_if.slave  load_m,
    mem_bus_if.master ram
);

    logic busy;    // Transfer in flight
    logic owner;   // Requester index of that transfer
    logic last;    // Last granted, loses the next tie
    logic grant;
    logic sel;
    logic accept;

    // Round-robin pick among current requests
    always_comb begin
        if (cpu_m.req && load_m.req) begin
            grant = (last == req_cpu) ? req_loader : req_cpu;
        end else if (load_m.req) begin
            grant = req_loader;
        end else begin
            grant = req_cpu;
        end
    end

    // Owner stays on the port until its ack
    assign sel    = busy ? owner : grant;
    assign accept = !busy && ram.req;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            owner <= req_cpu;
            last  <= req_loader;   // CPU wins the first tie
        end else if (accept) begin
            busy  <= 1'b1;
            owner <= sel;
        end else if (ram.ack) begin
            busy  <= 1'b0;
            last  <= owner;
        end
    end

    // Request side mux
    always_comb begin
        if (sel == req_loader) begin
            ram.req   = load_m.req;
            ram.we    = load_m.we;
            ram.addr  = load_m.addr;
            ram.wdata = load_m.wdata;
        end else begin
            ram.req   = cpu_m.req;
            ram.we    = cpu_m.we;
            ram.addr  = cpu_m.addr;
            ram.wdata = cpu_m.wdata;
        end
    end

    // Response goes back to the owner only
    assign cpu_m.ack    = ram.ack && busy && (owner == req_cpu);
    assign load_m.ack   = ram.ack && busy && (owner == req_loader);
    assign cpu_m.rdata  = (owner == req_cpu)    ? ram.rdata : '0;
    assign load_m.rdata = (owner == req_loader) ? ram.rdata : '0;

endmodule

//--- hw/segment_mapper.sv
module segment_mapper import msx_bus_pkg::*, mapper_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [page_w-1:0]     seg_sel,
    input  logic                  seg_wr,
    input  logic                  seg_rd,
    input  logic [cpu_addr_w-1:0] cpu_addr,
    input  logic [cpu_data_w-1:0] cpu_wdata,
    input  logic                  cpu_mreq,
    input  logic                  cpu_rd,
    input  logic                  cpu_wr,
    output logic [cpu_data_w-1:0] io_rdata,
    output logic [cpu_data_w-1:0] cpu_rdata_mem,
    output logic                  cpu_wait,
    mem_bus_if.master             mem
);

    logic [seg_w-1:0]  seg_q [n_pages];   // One per page
    logic [page_w-1:0] page;
    logic              mem_cycle;
    logic              done;              // Transfer acked, CPU still holds mreq

    // Segment registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < n_pages; i++) begin
                seg_q[i] <= '0;
            end
        end else if (seg_wr) begin
            seg_q[seg_sel] <= seg_w'(cpu_wdata & seg_mask);   // Drop bits above mapper size
        end
    end

    // Unused high bits read back as ones
    assign io_rdata = seg_rd ? (cpu_data_w'(seg_q[seg_sel]) | ~seg_mask) : '1;

    // Page lookup
    assign page      = cpu_addr[cpu_addr_w-1:page_lsb];
    assign mem_cycle = cpu_mreq && (cpu_rd || cpu_wr);

    // Set on ack, cleared once the CPU lets go of mreq
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done <= 1'b0;
        end else if (!mem_cycle) begin
            done <= 1'b0;
        end else if (mem.ack) begin
            done <= 1'b1;
        end
    end

    assign mem.req   = mem_cycle && !done;
    assign mem.we    = cpu_wr;
    assign mem.addr  = {seg_q[page], cpu_addr[page_off_w-1:0]};
    assign mem.wdata = cpu_wdata;

    // Wait drops the cycle after ack
    assign cpu_wait = mem_cycle && !done;

    always_ff @(posedge clk) begin
        if (mem.ack && !mem.we) begin
            cpu_rdata_mem <= mem.rdata;
        end
    end

endmodule

//--- hw/io_port_decoder.sv
module io_port_decoder import msx_bus_pkg::*; (
    input  logic [cpu_addr_w-1:0] cpu_addr,
    input  logic                  cpu_iorq,
    input  logic                  cpu_m1,
    input  logic                  cpu_rd,
    input  logic                  cpu_wr,
    output logic [page_w-1:0]     seg_sel,
    output logic                  seg_wr,
    output logic                  seg_rd,
    output logic                  io_miss_rd
);

    logic                 io_cycle;
    logic [io_port_w-1:0] port_off;
    logic                 port_hit;

    // M1 together with IORQ is an interrupt acknowledge, not a port access
    assign io_cycle = cpu_iorq && !cpu_m1;

    // Offset from FC, wraps for ports below it
    assign port_off = cpu_addr[io_port_w-1:0] - port_seg_base;
    assign port_hit = port_off < io_port_w'(n_pages);

    assign seg_sel    = port_off[page_w-1:0];
    assign seg_wr     = io_cycle && port_hit && cpu_wr;
    assign seg_rd     = io_cycle && port_hit && cpu_rd;
    assign io_miss_rd = io_cycle && !port_hit && cpu_rd;   // Top returns FF

endmodule

//--- hw/mem_bus_if.sv
interface mem_bus_if import msx_bus_pkg::*, mapper_pkg::*; ();

    logic                  req;     // Held until ack
    logic                  we;
    logic [phys_aw-1:0]    addr;
    logic [cpu_data_w-1:0] wdata;
    logic [cpu_data_w-1:0] rdata;   // Valid in the ack cycle
    logic                  ack;     // One-cycle pulse

    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

//--- hw/mapper_pkg.sv
package mapper_pkg;

    // Fixed mapper size, 8 segments of 16 KB = 128 KB
    localparam int mapper_segments = 8;
    localparam int seg_w           = $clog2(mapper_segments);

    // Bits kept on a segment register write
    localparam logic [msx_bus_pkg::cpu_data_w-1:0] seg_mask =
        msx_bus_pkg::cpu_data_w'(mapper_segments - 1);

    // Segment number on top of the page offset
    localparam int phys_aw = seg_w + msx_bus_pkg::page_off_w;

    // Arbiter requester indices
    localparam logic req_cpu    = 1'b0;
    localparam logic req_loader = 1'b1;

endpackage

//--- hw/msx_bus_pkg.sv
package msx_bus_pkg;

    // Z80 bus widths
    localparam int cpu_addr_w = 16;
    localparam int cpu_data_w = 8;
    localparam int io_port_w  = 8;   // I/O decode uses the low address byte only

    // Mapper I/O ports, page 0 at FC, pages 1 to 3 follow
    localparam logic [io_port_w-1:0] port_seg_base = 8'hFC;

    // Page field sits at the top of the CPU address
    localparam int page_lsb   = 14;
    localparam int page_w     = cpu_addr_w - page_lsb;   // 2 bits, four pages
    localparam int n_pages    = 1 << page_w;
    localparam int page_off_w = page_lsb;                // 16 KB per page

endpackage
